/* design/sound_cfg_pkg.sv */
// Rates hold only for a 24 MHz clk and change with CEN_NUM and CEN_DEN if the clock differs
package sound_cfg_pkg;

    // Fractional enable ratio
    // 3.579545 MHz out of 24 MHz, both terms divided by 5
    localparam int CEN_NUM = 715909;
    localparam int CEN_DEN = 4800000;

    // Accumulator must hold CEN_DEN + CEN_NUM without wrapping
    // 5.5e6 fits easily in 24 bits
    localparam int CEN_ACC_W = 24;

    // Accumulator word for the enable divider
    typedef logic [CEN_ACC_W-1:0] cen_acc_t;

    // FM enables per output sample
    // 64 x 6.7 clk gives 429 or 430 clk per sample
    localparam int FM_TICKS_PER_SAMPLE = 64;

    // Counter width for the sample divider
    // Power of two keeps the wrap free
    localparam int TICK_W = $clog2(FM_TICKS_PER_SAMPLE);

    // Counts FM enables within one sample
    typedef logic [TICK_W-1:0] tick_cnt_t;

    // Output level per volume step
    // Full volume is 7 x 2048 = 14336
    localparam int AMP_STEP = 2048;

    // Square wave voices in the mixer
    // Two full scale voices sum to 28672, below the 16-bit limit
    localparam int VOICES = 2;

endpackage

/* design/sound_data_pkg.sv */
// Script layout is fixed at three bytes per entry and the pointer table must sit in the low 512 bytes
package sound_data_pkg;

    // Field widths
    localparam int ROM_AW = 16;
    localparam int VOL_W  = 3;
    localparam int PAN_W  = 2;

    // Sound ROM byte address and data
    typedef logic [ROM_AW-1:0] rom_addr_t;
    typedef logic [7:0]        rom_byte_t;

    // Command byte from the main CPU
    typedef logic [7:0] cmd_t;

    // Signed output level
    typedef logic signed [15:0] sample_t;

    // Note timing, both counted in samples
    typedef logic [7:0] period_t;
    typedef logic [7:0] dur_t;

    // Voice volume and pan
    typedef logic [VOL_W-1:0] vol_t;
    typedef logic [PAN_W-1:0] pan_t;

    // Pan bits
    localparam int PAN_LEFT_BIT  = 1;
    localparam int PAN_RIGHT_BIT = 0;

    // Pointer table, two bytes per command, high byte first
    localparam rom_addr_t PTR_BASE = 16'h0000;

    // Entry is control, period, duration
    localparam int ENTRY_BYTES = 3;

    // Control byte fields
    localparam int CTRL_END_BIT   = 7;
    localparam int CTRL_VOL_LSB   = 4;
    localparam int CTRL_PAN_LSB   = 1;
    localparam int CTRL_VOICE_BIT = 0;

    // Script reader FSM
    typedef enum logic [2:0] {
        idle,
        ptr_hi,
        ptr_lo,
        ent_ctrl,
        ent_period,
        ent_dur,
        hold
    } reader_state_t;

endpackage

/* design/sound_cen.sv */
// cen_fm jitters between 6 and 7 clk cycles and is only right for a 24 MHz clk
`timescale 1ns/1ps

module sound_cen (
    input  logic clk,
    input  logic reset,
    output logic cen_fm,
    output logic sample_tick
);

// Phase accumulator
sound_cfg_pkg::cen_acc_t  acc;
sound_cfg_pkg::cen_acc_t  acc_sum;
// FM enables seen in the current sample
sound_cfg_pkg::tick_cnt_t tick_cnt;
logic                     acc_wrap;

// Next phase before wrap
assign acc_sum  = acc + sound_cfg_pkg::cen_acc_t'(sound_cfg_pkg::CEN_NUM);
// Crossing the denominator gives one enable
assign acc_wrap = acc_sum >= sound_cfg_pkg::cen_acc_t'(sound_cfg_pkg::CEN_DEN);

always_ff @(posedge clk) begin
    if (reset) begin
        acc         <= '0;
        tick_cnt    <= '0;
        cen_fm      <= 1'b0;
        sample_tick <= 1'b0;
    end else begin
        // Strobes are one cycle wide
        cen_fm      <= 1'b0;
        sample_tick <= 1'b0;
        if (acc_wrap) begin
            // Keep the remainder so the mean rate is exact
            acc      <= acc_sum - sound_cfg_pkg::cen_acc_t'(sound_cfg_pkg::CEN_DEN);
            cen_fm   <= 1'b1;
            tick_cnt <= tick_cnt + 1'b1;
            // Last enable of the sample also fires the sample strobe
            if (tick_cnt == sound_cfg_pkg::tick_cnt_t'(sound_cfg_pkg::FM_TICKS_PER_SAMPLE - 1))
            begin
                sample_tick <= 1'b1;
            end
        end else begin
            acc <= acc_sum;
        end
    end
end

endmodule

/* design/sound_script_reader.sv */
// snd_latch is only looked at on cen_fm and a command must change to be seen again
`timescale 1ns/1ps

module sound_script_reader (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      cen_fm,
    input  logic                      sample_tick,
    // Main CPU command
    input  sound_data_pkg::cmd_t      snd_latch,
    // Sound ROM
    input  sound_data_pkg::rom_byte_t rom_data,
    input  logic                      rom_ok,
    output sound_data_pkg::rom_addr_t rom_addr,
    output logic                      rom_cs,
    // Note to the voices
    output logic                      note_load,
    output logic                      note_voice,
    output sound_data_pkg::vol_t      note_vol,
    output sound_data_pkg::pan_t      note_pan,
    output sound_data_pkg::period_t   note_period,
    output logic                      silence
);

sound_data_pkg::reader_state_t state;

// Command tracking
sound_data_pkg::cmd_t      latch_prev;
sound_data_pkg::cmd_t      cmd_q;
// Fetched bytes
sound_data_pkg::rom_byte_t ptr_hi_q;
sound_data_pkg::rom_byte_t ctrl_q;
sound_data_pkg::period_t   period_q;
// Base of the current entry
sound_data_pkg::rom_addr_t ent_addr;
sound_data_pkg::rom_addr_t ptr_addr;
sound_data_pkg::rom_addr_t next_addr;
// Samples left in the note
sound_data_pkg::dur_t      dur_cnt;

logic new_cmd;
logic fetching;
// ROM gets one full cycle with a stable address
logic addr_settled;

// Change seen on an FM enable means a new command
assign new_cmd  = cen_fm && (snd_latch != latch_prev);

// Every state except idle and hold reads a byte
assign fetching = (state != sound_data_pkg::idle) && (state != sound_data_pkg::hold);

// Pointer pair for the current command
assign ptr_addr = sound_data_pkg::PTR_BASE + sound_data_pkg::rom_addr_t'({cmd_q, 1'b0});

// Address of the byte this state reads
always_comb begin
    case (state)
        sound_data_pkg::ptr_hi:     next_addr = ptr_addr;
        sound_data_pkg::ptr_lo:     next_addr = ptr_addr + 1'b1;
        sound_data_pkg::ent_period: next_addr = ent_addr + 1'b1;
        sound_data_pkg::ent_dur:    next_addr = ent_addr + 2'd2;
        default:                    next_addr = ent_addr;
    endcase
end

always_ff @(posedge clk) begin
    if (reset) begin
        state        <= sound_data_pkg::idle;
        latch_prev   <= '0;
        cmd_q        <= '0;
        rom_addr     <= '0;
        rom_cs       <= 1'b0;
        addr_settled <= 1'b0;
        dur_cnt      <= '0;
        note_load    <= 1'b0;
        silence      <= 1'b0;
    end else begin
        // Pulses
        note_load <= 1'b0;
        silence   <= 1'b0;
        if (cen_fm) begin
            latch_prev <= snd_latch;
        end
        if (new_cmd) begin
            // Abort whatever is in flight
            rom_cs <= 1'b0;
            cmd_q  <= snd_latch;
            if (snd_latch == '0) begin
                // Stop command
                silence <= 1'b1;
                state   <= sound_data_pkg::idle;
            end else begin
                state <= sound_data_pkg::ptr_hi;
            end
        end else if (fetching) begin
            if (!rom_cs) begin
                // Start a read
                rom_addr     <= next_addr;
                rom_cs       <= 1'b1;
                addr_settled <= 1'b0;
            end else if (!addr_settled) begin
                addr_settled <= 1'b1;
            end else if (rom_ok) begin
                // Byte arrived, drop cs for a cycle
                rom_cs <= 1'b0;
                case (state)
                    sound_data_pkg::ptr_hi: begin
                        ptr_hi_q <= rom_data;
                        state    <= sound_data_pkg::ptr_lo;
                    end
                    sound_data_pkg::ptr_lo: begin
                        ent_addr <= {ptr_hi_q, rom_data};
                        state    <= sound_data_pkg::ent_ctrl;
                    end
                    sound_data_pkg::ent_ctrl: begin
                        if (rom_data[sound_data_pkg::CTRL_END_BIT]) begin
                            // End of script, nothing loaded
                            silence <= 1'b1;
                            state   <= sound_data_pkg::idle;
                        end else begin
                            ctrl_q <= rom_data;
                            state  <= sound_data_pkg::ent_period;
                        end
                    end
                    sound_data_pkg::ent_period: begin
                        period_q <= rom_data;
                        state    <= sound_data_pkg::ent_dur;
                    end
                    sound_data_pkg::ent_dur: begin
                        // Entry complete
                        note_load   <= 1'b1;
                        note_voice  <= ctrl_q[sound_data_pkg::CTRL_VOICE_BIT];
                        note_vol    <= ctrl_q[sound_data_pkg::CTRL_VOL_LSB +: sound_data_pkg::VOL_W];
                        note_pan    <= ctrl_q[sound_data_pkg::CTRL_PAN_LSB +: sound_data_pkg::PAN_W];
                        note_period <= period_q;
                        dur_cnt     <= rom_data;
                        ent_addr    <= ent_addr
                                       + sound_data_pkg::rom_addr_t'(sound_data_pkg::ENTRY_BYTES);
                        state       <= sound_data_pkg::hold;
                    end
                    default: begin
                        state <= sound_data_pkg::idle;
                    end
                endcase
            end
        end else if (state == sound_data_pkg::hold) begin
            // Note plays for dur_cnt samples
            if (dur_cnt == '0) begin
                state <= sound_data_pkg::ent_ctrl;
            end else if (sample_tick) begin
                dur_cnt <= dur_cnt - 1'b1;
            end
        end
    end
end

endmodule

/* design/sound_voice_mixer.sv */
// Levels change only on sample_tick and a loaded note is heard from the sample after the load
`timescale 1ns/1ps

module sound_voice_mixer (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    sample_tick,
    // Note from the reader
    input  logic                    note_load,
    input  logic                    note_voice,
    input  sound_data_pkg::vol_t    note_vol,
    input  sound_data_pkg::pan_t    note_pan,
    input  sound_data_pkg::period_t note_period,
    input  logic                    silence,
    // Sound output
    output sound_data_pkg::sample_t left,
    output sound_data_pkg::sample_t right,
    output logic                    sample
);

// Note waiting for the next sample
logic                    pend_valid;
logic                    pend_voice;
sound_data_pkg::vol_t    pend_vol;
sound_data_pkg::pan_t    pend_pan;
sound_data_pkg::period_t pend_period;

// Per voice state
sound_data_pkg::period_t per_r   [sound_cfg_pkg::VOICES];
sound_data_pkg::vol_t    vol_r   [sound_cfg_pkg::VOICES];
sound_data_pkg::pan_t    pan_r   [sound_cfg_pkg::VOICES];
sound_data_pkg::period_t phase_r [sound_cfg_pkg::VOICES];
logic                    pol_r   [sound_cfg_pkg::VOICES];

// Signed level of each voice
sound_data_pkg::sample_t level   [sound_cfg_pkg::VOICES];
sound_data_pkg::sample_t left_sum;
sound_data_pkg::sample_t right_sum;

// Pending flag
always_ff @(posedge clk) begin
    if (reset) begin
        pend_valid <= 1'b0;
    end else if (silence) begin
        // Stop also drops a note not yet played
        pend_valid <= 1'b0;
    end else if (note_load) begin
        pend_valid <= 1'b1;
    end else if (sample_tick) begin
        pend_valid <= 1'b0;
    end
end

// Staged note fields
always_ff @(posedge clk) begin
    if (note_load) begin
        pend_voice  <= note_voice;
        pend_vol    <= note_vol;
        pend_pan    <= note_pan;
        pend_period <= note_period;
    end
end

// Square wave generators
always_ff @(posedge clk) begin
    if (reset) begin
        for (int v = 0; v < sound_cfg_pkg::VOICES; v++) begin
            per_r[v]   <= '0;
            vol_r[v]   <= '0;
            pan_r[v]   <= '0;
            phase_r[v] <= '0;
            pol_r[v]   <= 1'b0;
        end
    end else begin
        for (int v = 0; v < sound_cfg_pkg::VOICES; v++) begin
            if (sample_tick) begin
                if (pend_valid && (pend_voice == 1'(v))) begin
                    // New note restarts positive
                    per_r[v]   <= pend_period;
                    vol_r[v]   <= pend_vol;
                    pan_r[v]   <= pend_pan;
                    phase_r[v] <= '0;
                    pol_r[v]   <= 1'b0;
                end else if (phase_r[v] == per_r[v]) begin
                    // Half period is period plus one samples
                    phase_r[v] <= '0;
                    pol_r[v]   <= ~pol_r[v];
                end else begin
                    phase_r[v] <= phase_r[v] + 1'b1;
                end
            end
            // Silence wins over a load on the same cycle
            if (silence) begin
                vol_r[v] <= '0;
            end
        end
    end
end

// Level and pan sums
always_comb begin
    left_sum  = '0;
    right_sum = '0;
    for (int v = 0; v < sound_cfg_pkg::VOICES; v++) begin
        level[v] = sound_data_pkg::sample_t'(vol_r[v])
                   * sound_data_pkg::sample_t'(sound_cfg_pkg::AMP_STEP);
        if (pol_r[v]) begin
            level[v] = -level[v];
        end
        if (pan_r[v][sound_data_pkg::PAN_LEFT_BIT]) begin
            left_sum = left_sum + level[v];
        end
        if (pan_r[v][sound_data_pkg::PAN_RIGHT_BIT]) begin
            right_sum = right_sum + level[v];
        end
    end
end

// Registered outputs
always_ff @(posedge clk) begin
    if (reset) begin
        left   <= '0;
        right  <= '0;
        sample <= 1'b0;
    end else begin
        // Marks the new output value
        sample <= sample_tick;
        if (sample_tick) begin
            left  <= left_sum;
            right <= right_sum;
        end
    end
end

endmodule

/* design/sound_top.sv */
// ROM must hold rom_data valid while rom_ok is high and rom_addr stays still while rom_cs is high
`timescale 1ns/1ps

module sound_top (
    input  logic                      clk,
    input  logic                      reset,
    // Main CPU command
    input  sound_data_pkg::cmd_t      snd_latch,
    // Sound ROM
    output sound_data_pkg::rom_addr_t rom_addr,
    output logic                      rom_cs,
    input  sound_data_pkg::rom_byte_t rom_data,
    input  logic                      rom_ok,
    // Sound output
    output sound_data_pkg::sample_t   left,
    output sound_data_pkg::sample_t   right,
    output logic                      sample
);

// Enables
logic                    cen_fm;
logic                    sample_tick;
// Reader to voices
logic                    note_load;
logic                    note_voice;
sound_data_pkg::vol_t    note_vol;
sound_data_pkg::pan_t    note_pan;
sound_data_pkg::period_t note_period;
logic                    silence;

sound_cen u_cen (
    .clk         ( clk         ),
    .reset       ( reset       ),
    .cen_fm      ( cen_fm      ),
    .sample_tick ( sample_tick )
);

sound_script_reader u_reader (
    .clk         ( clk         ),
    .reset       ( reset       ),
    .cen_fm      ( cen_fm      ),
    .sample_tick ( sample_tick ),
    .snd_latch   ( snd_latch   ),
    .rom_data    ( rom_data    ),
    .rom_ok      ( rom_ok      ),
    .rom_addr    ( rom_addr    ),
    .rom_cs      ( rom_cs      ),
    .note_load   ( note_load   ),
    .note_voice  ( note_voice  ),
    .note_vol    ( note_vol    ),
    .note_pan    ( note_pan    ),
    .note_period ( note_period ),
    .silence     ( silence     )
);

sound_voice_mixer u_mixer (
    .clk         ( clk         ),
    .reset       ( reset       ),
    .sample_tick ( sample_tick ),
    .note_load   ( note_load   ),
    .note_voice  ( note_voice  ),
    .note_vol    ( note_vol    ),
    .note_pan    ( note_pan    ),
    .note_period ( note_period ),
    .silence     ( silence     ),
    .left        ( left        ),
    .right       ( right       ),
    .sample      ( sample      )
);

endmodule

/* sim/sound_tb_rom.sv */
// Sound ROM model with data returned combinationally and rom_ok raised 1 to 8 cycles after a new request
`timescale 1ns/1ps

module sound_tb_rom (
    input  logic                      clk,
    input  logic                      reset,
    input  sound_data_pkg::rom_addr_t rom_addr,
    input  logic                      rom_cs,
    output sound_data_pkg::rom_byte_t rom_data,
    output logic                      rom_ok
);

logic [7:0]                mem [0:65535];
// Latency source, Galois form
logic [15:0]               lfsr = 16'd4960;
logic [3:0]                wait_cnt;
logic                      cs_q = 1'b0;
sound_data_pkg::rom_addr_t addr_q;

function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
endfunction

// Control, period and duration bytes of one script entry
task automatic write_entry(input int a, input logic [7:0] ctrl, input logic [7:0] period,
                           input logic [7:0] dur);
    mem[a]     = ctrl;
    mem[a + 1] = period;
    mem[a + 2] = dur;
endtask

initial begin
    // Background mixes every address bit
    for (int a = 0; a < 65536; a++) begin
        mem[a] = 8'(a ^ (a >> 8) ^ 8'hA5);
    end
    // Pointer table, high byte first
    mem[2] = 8'h01;
    mem[3] = 8'h00;
    mem[4] = 8'h01;
    mem[5] = 8'h20;
    mem[6] = 8'h01;
    mem[7] = 8'h40;
    // Command 1, voice 0 both sides then voice 1 left
    write_entry(16'h0100, 8'h56, 8'd3, 8'd24);
    write_entry(16'h0103, 8'h25, 8'd1, 8'd12);
    mem[16'h0106] = 8'h80;
    // Command 2, one long note on voice 1 right
    write_entry(16'h0120, 8'h73, 8'd0, 8'd200);
    mem[16'h0123] = 8'h80;
    // Command 3
    write_entry(16'h0140, 8'h14, 8'd2, 8'd6);
    write_entry(16'h0143, 8'h37, 8'd4, 8'd10);
    mem[16'h0146] = 8'h80;
end

assign rom_data = mem[rom_addr];

always @(posedge clk) begin : latency
    logic [2:0] bits;
    if (reset) begin
        rom_ok   <= 1'b0;
        wait_cnt <= '0;
    end else if (!rom_cs) begin
        rom_ok   <= 1'b0;
        wait_cnt <= '0;
    end else if (!cs_q || (rom_addr != addr_q)) begin
        // New request, one LFSR step per bit
        for (int b = 0; b < 3; b++) begin
            bits = {bits[1:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
        rom_ok   <= 1'b0;
        wait_cnt <= {1'b0, bits} + 4'd1;
    end else if (wait_cnt != '0) begin
        wait_cnt <= wait_cnt - 1'b1;
        if (wait_cnt == 4'd1) begin
            rom_ok <= 1'b1;
        end
    end
    cs_q   <= rom_cs;
    addr_q <= rom_addr;
end

endmodule

/* sim/sound_tb.sv */
// Rows must write new commands while the old script holds a note, so no ROM read is in flight
`timescale 1ns/1ps

module sound_tb;

localparam int CLK_HALF = 20;
localparam int ROWS     = 5;

logic                      clk;
logic                      reset;
sound_data_pkg::cmd_t      snd_latch;
sound_data_pkg::rom_addr_t rom_addr;
sound_data_pkg::rom_byte_t rom_data;
logic                      rom_cs;
logic                      rom_ok;
logic                      sample;
sound_data_pkg::sample_t   left;
sound_data_pkg::sample_t   right;

// Command, notes loaded before the next row, script reaches its end, samples held
int row_cmd   [ROWS] = '{1, 2, 3, 1, 0};
int row_notes [ROWS] = '{2, 1, 2, 1, 0};
int row_ends  [ROWS] = '{1, 0, 1, 0, 0};
int row_hold  [ROWS] = '{4, 20, 4, 6, 4};

int errors = 0;
int checks = 0;
// Expected ROM fetch order of the running command
int exp_addr [$];
int cap_idx  = 0;

// Reference voices
int         m_vol   [2];
logic [1:0] m_pan   [2];
int         m_per   [2];
int         m_phase [2];
logic       m_pol   [2];
bit         pend     = 0;
int         pend_voice;
int         pend_vol;
logic [1:0] pend_pan;
int         pend_per;
int         pend_cyc;
bit         sil_pend = 0;
int         sil_cyc;
int         skip     = 0;

// Monitor history
int                        cyc        = 0;
int                        last_pulse = 0;
logic                      prev_sample = 1'b0;
logic                      prev_cs     = 1'b0;
sound_data_pkg::rom_addr_t prev_addr;
sound_data_pkg::cmd_t      mon_cmd     = '0;

sound_top i_dut (
    .clk       ( clk       ),
    .reset     ( reset     ),
    .snd_latch ( snd_latch ),
    .rom_addr  ( rom_addr  ),
    .rom_cs    ( rom_cs    ),
    .rom_data  ( rom_data  ),
    .rom_ok    ( rom_ok    ),
    .left      ( left      ),
    .right     ( right     ),
    .sample    ( sample    )
);

sound_tb_rom i_rom (
    .clk      ( clk      ),
    .reset    ( reset    ),
    .rom_addr ( rom_addr ),
    .rom_cs   ( rom_cs   ),
    .rom_data ( rom_data ),
    .rom_ok   ( rom_ok   )
);

initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
end

task automatic check_value(input string name, input int got, input int expected);
    checks++;
    assert (got == expected) else begin
        $display("CHECK FAILED at %0t: %s expected %0d got %0d", $time, name, expected, got);
        errors++;
    end
endtask

// Pointer pair, then three bytes per entry up to the end control byte
task automatic build_expected(input int cmd);
    int p;
    int a;
    exp_addr.delete();
    if (cmd != 0) begin
        p = int'(sound_data_pkg::PTR_BASE) + 2 * cmd;
        exp_addr.push_back(p);
        exp_addr.push_back(p + 1);
        a = {i_rom.mem[p], i_rom.mem[p + 1]};
        for (int e = 0; e < 16; e++) begin
            exp_addr.push_back(a);
            if (i_rom.mem[a][sound_data_pkg::CTRL_END_BIT]) begin
                break;
            end
            exp_addr.push_back(a + 1);
            exp_addr.push_back(a + 2);
            a = a + sound_data_pkg::ENTRY_BYTES;
        end
    end
endtask

task automatic wait_captures(input int target);
    int cnt;
    cnt = 0;
    while (cap_idx < target && cnt < 60000) begin
        @(posedge clk);
        cnt++;
    end
    assert (cap_idx >= target) else begin
        $display("TIMEOUT at %0t: ROM read %0d of the script never arrived", $time, cap_idx);
        errors++;
    end
endtask

// No ROM read is expected while only samples are counted
task automatic wait_samples(input int n);
    int seen;
    int cnt;
    seen = 0;
    cnt  = 0;
    while (seen < n && cnt < 440 * n + 100) begin
        @(posedge clk);
        cnt++;
        if (sample) begin
            seen++;
        end
        check_value("rom_cs", rom_cs, 0);
    end
    assert (seen >= n) else begin
        $display("TIMEOUT at %0t: only %0d of %0d sample strobes arrived", $time, seen, n);
        errors++;
    end
endtask

always @(posedge clk) begin : monitor
    int         idx;
    int         base;
    int         lvl;
    int         exp_l;
    int         exp_r;
    logic [7:0] ctrl;
    cyc++;
    if (rom_cs && prev_cs) begin
        check_value("rom_addr while rom_cs", rom_addr, prev_addr);
    end
    prev_cs   = rom_cs;
    prev_addr = rom_addr;
    // Stop silences both voices and drops a staged note
    if (snd_latch != mon_cmd) begin
        mon_cmd = snd_latch;
        if (snd_latch == '0) begin
            m_vol[0] = 0;
            m_vol[1] = 0;
            pend     = 0;
            sil_pend = 0;
            // Detection point jitters by one FM enable
            skip     = 1;
        end
    end
    // Capture cycle of the reader
    if (rom_cs && rom_ok) begin
        assert (cap_idx < exp_addr.size()) else begin
            $display("ERROR at %0t: ROM read at %h after the script should have ended",
                     $time, rom_addr);
            errors++;
        end
        if (cap_idx < exp_addr.size()) begin
            check_value("rom_addr", rom_addr, exp_addr[cap_idx]);
            idx = cap_idx - 2;
            if (idx >= 0 && idx % 3 == 2) begin
                // Duration byte completes the note
                base       = exp_addr[cap_idx] - 2;
                ctrl       = i_rom.mem[base];
                pend       = 1;
                pend_cyc   = cyc;
                pend_voice = ctrl[sound_data_pkg::CTRL_VOICE_BIT];
                pend_vol   = ctrl[sound_data_pkg::CTRL_VOL_LSB +: 3];
                pend_pan   = ctrl[sound_data_pkg::CTRL_PAN_LSB +: 2];
                pend_per   = i_rom.mem[base + 1];
            end else if (idx >= 0 && cap_idx == exp_addr.size() - 1) begin
                sil_pend = 1;
                sil_cyc  = cyc;
            end
        end
        cap_idx++;
    end
    if (sample) begin
        assert (!prev_sample) else begin
            $display("ERROR at %0t: sample strobe wider than one cycle", $time);
            errors++;
        end
        if (last_pulse != 0) begin
            checks++;
            assert (cyc - last_pulse == 429 || cyc - last_pulse == 430) else begin
                $display("CHECK FAILED at %0t: sample spacing expected 429 or 430 got %0d",
                         $time, cyc - last_pulse);
                errors++;
            end
        end
        last_pulse = cyc;
        // Silence must be two cycles old to reach the tick before this strobe
        if (sil_pend && sil_cyc <= cyc - 3) begin
            m_vol[0] = 0;
            m_vol[1] = 0;
            pend     = 0;
            sil_pend = 0;
        end
        exp_l = 0;
        exp_r = 0;
        for (int v = 0; v < 2; v++) begin
            lvl = m_vol[v] * sound_cfg_pkg::AMP_STEP;
            if (m_pol[v]) begin
                lvl = -lvl;
            end
            if (m_pan[v][1]) begin
                exp_l = exp_l + lvl;
            end
            if (m_pan[v][0]) begin
                exp_r = exp_r + lvl;
            end
        end
        if (skip > 0) begin
            skip--;
        end else begin
            check_value("left", left, exp_l);
            check_value("right", right, exp_r);
        end
        // Advance voices for the tick behind this strobe
        for (int v = 0; v < 2; v++) begin
            if (pend && pend_cyc <= cyc - 3 && pend_voice == v) begin
                m_vol[v]   = pend_vol;
                m_pan[v]   = pend_pan;
                m_per[v]   = pend_per;
                m_phase[v] = 0;
                m_pol[v]   = 1'b0;
            end else if (m_phase[v] == m_per[v]) begin
                m_phase[v] = 0;
                m_pol[v]   = ~m_pol[v];
            end else begin
                m_phase[v]++;
            end
        end
        if (pend && pend_cyc <= cyc - 3) begin
            pend = 0;
        end
    end
    prev_sample = sample;
end

initial begin
    int target;
    int err0;
    reset     = 1'b1;
    snd_latch = '0;
    for (int v = 0; v < 2; v++) begin
        m_pan[v] = 2'b00;
        m_pol[v] = 1'b0;
    end
    for (int i = 0; i < 5; i++) begin
        @(posedge clk);
        if (i > 0) begin
            check_value("rom_cs", rom_cs, 0);
            check_value("left", left, 0);
            check_value("right", right, 0);
        end
    end
    reset <= 1'b0;
    wait_samples(3);
    $display("test reset: %0d errors", errors);
    for (int r = 0; r < ROWS; r++) begin
        err0 = errors;
        build_expected(row_cmd[r]);
        cap_idx = 0;
        @(posedge clk);
        snd_latch <= sound_data_pkg::cmd_t'(row_cmd[r]);
        target = (row_notes[r] == 0) ? 0 : 2 + 3 * row_notes[r] + row_ends[r];
        wait_captures(target);
        wait_samples(row_hold[r]);
        $display("test %0d cmd %0d: %0d errors", r, row_cmd[r], errors - err0);
    end
    $display("tests: %0d, checks: %0d, errors: %0d", ROWS + 1, checks, errors);
    if (errors == 0) begin
        $display("Done: no errors");
    end else begin
        $display("Done: errors found");
    end
    $finish;
end

endmodule

/* sim.f */
design/sound_cfg_pkg.sv
design/sound_data_pkg.sv
design/sound_cen.sv
design/sound_script_reader.sv
design/sound_voice_mixer.sv
design/sound_top.sv
sim/sound_tb_rom.sv
sim/sound_tb.sv
